/* build.f */
+incdir+verilog
verilog/sha256_pkg.sv
verilog/sha256_k_constants.sv
verilog/sha256_w_mem.sv
verilog/sha256_core.sv
verilog/sha256.sv
verilog/pmu_auth.sv
verif/clock_gen.sv
verif/tb_pmu_auth.sv

/* verif/tb_pmu_auth.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sha256_defs.svh"

module tb_pmu_auth;
    import sha256_pkg::*;

    localparam int NUM_CASES    = 6;
    localparam int RESET_CYCLES = 16;
    localparam int PERIOD_NS    = 20;
    localparam int LATENCY      = `SHA_ROUNDS + 1;    // cs edge to ready rising

    localparam logic [1:0] CORRUPT_NONE   = 2'd0;
    localparam logic [1:0] CORRUPT_DIGEST = 2'd1;
    localparam logic [1:0] CORRUPT_KEY    = 2'd2;

    // Hash of the empty string, and the hash of that hash
    localparam digest_t VEC_A_KEY =
        256'he3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855;
    localparam digest_t VEC_A_DIGEST =
        256'h5df6e0e2761359d30a8275058e299fcc0381534545f55cf43e41983f5d4c9456;
    // 32 zero bytes
    localparam digest_t VEC_B_KEY = '0;
    localparam digest_t VEC_B_DIGEST =
        256'h66687aadf862bd776c8fc18b8e9f8e20089714856ee233b3902a591d0d5f2925;

    logic       clk;
    logic       reset_n;
    logic       cs;
    logic       we;
    logic       wc;
    word_addr_t address;
    word_t      write_data;
    wire        ready;
    wire        digest_valid;

    //==========================================================================
    // Stimulus table
    //==========================================================================

    digest_t    case_key     [NUM_CASES];
    digest_t    case_digest  [NUM_CASES];
    logic [1:0] case_corrupt [NUM_CASES];
    logic       case_busy_wr [NUM_CASES];   // Key writes while the core runs
    logic       case_hold    [NUM_CASES];   // Register writes with no cs afterwards
    logic       case_expect  [NUM_CASES];

    logic [31:0] rng_state;

    clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    pmu_auth DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .cs           (cs),
        .we           (we),
        .wc           (wc),
        .address      (address),
        .write_data   (write_data),
        .ready        (ready),
        .digest_valid (digest_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_case(input int idx, input digest_t key, input digest_t digest,
                            input logic [1:0] corrupt, input logic busy_wr,
                            input logic hold, input logic expect_valid);
        case_key[idx]     = key;
        case_digest[idx]  = digest;
        case_corrupt[idx] = corrupt;
        case_busy_wr[idx] = busy_wr;
        case_hold[idx]    = hold;
        case_expect[idx]  = expect_valid;
    endtask

    task automatic fill_table();
        set_case(0, VEC_A_KEY, VEC_A_DIGEST, CORRUPT_NONE,   1'b0, 1'b0, 1'b1);
        set_case(1, VEC_B_KEY, VEC_B_DIGEST, CORRUPT_NONE,   1'b0, 1'b0, 1'b1);
        set_case(2, VEC_A_KEY, VEC_A_DIGEST, CORRUPT_DIGEST, 1'b0, 1'b0, 1'b0);
        set_case(3, VEC_B_KEY, VEC_B_DIGEST, CORRUPT_KEY,    1'b0, 1'b1, 1'b0);
        set_case(4, VEC_B_KEY, VEC_B_DIGEST, CORRUPT_NONE,   1'b1, 1'b0, 1'b1);
        set_case(5, VEC_A_KEY, VEC_A_DIGEST, CORRUPT_NONE,   1'b0, 1'b0, 1'b1);
    endtask

    // Inputs change and outputs are read 2 ns after the rising edge
    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic write_word(input logic to_block, input int addr, input word_t data);
        we         = 1'b1;
        wc         = to_block;
        address    = addr[2:0];
        write_data = data;
        next_edge();
        we         = 1'b0;
    endtask

    task automatic write_key(input digest_t key);
        for (int i = 0; i < `SHA_WORDS; i++) begin
            write_word(1'b1, i, key[32*i +: 32]);    // Address 7 is the top word
        end
    endtask

    task automatic write_digest(input digest_t digest);
        for (int i = 0; i < `SHA_WORDS; i++) begin
            write_word(1'b0, i, digest[32*i +: 32]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s actual %0h expected %0h",
                     $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at first error");
        end
    endtask

    //==========================================================================
    // Main sequence
    //==========================================================================

    initial begin
        digest_t key;
        digest_t digest;
        int      cycles;
        int      flip;

        cs          = 1'b0;
        we          = 1'b0;
        wc          = 1'b0;
        address     = '0;
        write_data  = '0;
        rng_state   = 32'hc33e;
        fill_table();

        @(posedge reset_n);
        next_edge();
        check_value("ready", ready, 1);
        check_value("digest_valid", digest_valid, 0);

        for (int n = 0; n < NUM_CASES; n++) begin
            key    = case_key[n];
            digest = case_digest[n];
            if (case_corrupt[n] != CORRUPT_NONE) begin
                rng_state = xorshift32(rng_state);
                flip      = 32 * int'(rng_state[2:0]) + int'(rng_state[12:8]);
                if (case_corrupt[n] == CORRUPT_DIGEST) begin
                    digest[flip] = ~digest[flip];
                end else begin
                    key[flip] = ~key[flip];
                end
            end
            write_key(key);
            write_digest(digest);

            cs = 1'b1;
            next_edge();
            cs     = 1'b0;
            cycles = 0;
            while (!ready) begin
                if (case_busy_wr[n] && (cycles < `SHA_WORDS)) begin
                    rng_state  = xorshift32(rng_state);
                    we         = 1'b1;
                    wc         = 1'b1;
                    address    = cycles[2:0];
                    write_data = rng_state;    // Must not reach the running hash
                end else begin
                    we = 1'b0;
                end
                next_edge();
                cycles++;
            end
            we = 1'b0;
            check_value("ready_latency", cycles, LATENCY);

            next_edge();
            check_value("digest_valid", digest_valid, case_expect[n]);

            if (case_hold[n]) begin
                write_key(case_key[n]);
                write_digest(case_digest[n]);
                next_edge();
                next_edge();
                check_value("digest_valid_held", digest_valid, case_expect[n]);
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog of about 100 cycles per case plus reset
    initial begin
        #((NUM_CASES * 100 + RESET_CYCLES) * PERIOD_NS);
        $display("ERROR: watchdog expired, ready never returned to 1");
        $display("TESTS FAILED");
        $fatal(1, "Simulation timed out");
    end

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release reset just after a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/pmu_auth.sv */
`timescale 1ns/10ps
`default_nettype none

// PMU authentication subsystem boundary
module pmu_auth (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         cs,          // Start a hash of the stored key
    input  wire                         we,
    input  wire                         wc,
    input  wire sha256_pkg::word_addr_t address,
    input  wire sha256_pkg::word_t      write_data,
    output wire                         ready,
    output wire                         digest_valid // Held match result
);

    sha256 u_sha256 (
        .clk          (clk),
        .reset_n      (reset_n),
        .cs           (cs),
        .we           (we),
        .wc           (wc),
        .address      (address),
        .write_data   (write_data),
        .ready        (ready),
        .digest_valid (digest_valid)
    );

endmodule

`default_nettype wire

/* verilog/sha256.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sha256_defs.svh"

module sha256 (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         cs,
    input  wire                         we,
    input  wire                         wc,        // 1 selects block, 0 selects digest
    input  wire sha256_pkg::word_addr_t address,
    input  wire sha256_pkg::word_t      write_data,
    output wire                         ready,
    output logic                        digest_valid
);
    import sha256_pkg::*;

    // Zero fill between the stop bit and the length field
    localparam int PAD_ZEROS = 512 - `SHA_MSG_LEN_BITS - 1 - 64;

    word_t      block_reg  [`SHA_WORDS];
    word_t      digest_reg [`SHA_WORDS];
    digest_t    key_bits;
    digest_t    expected;
    msg_block_t block;
    digest_t    core_digest;
    logic       core_digest_valid;

    //==========================================================================
    // Host register file
    //==========================================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `SHA_WORDS; i++) begin
                block_reg[i]  <= '0;
                digest_reg[i] <= '0;
            end
        end else if (we) begin
            if (wc) begin
                block_reg[address] <= write_data;
            end else begin
                digest_reg[address] <= write_data;
            end
        end
    end

    // Address 7 is the most significant word
    always_comb begin
        for (int i = 0; i < `SHA_WORDS; i++) begin
            key_bits[32*i +: 32] = block_reg[i];
            expected[32*i +: 32] = digest_reg[i];
        end
    end

    // Key, stop bit, zeros, 64-bit message length
    assign block = {key_bits, 1'b1, {PAD_ZEROS{1'b0}}, 64'(`SHA_MSG_LEN_BITS)};

    sha256_core u_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .init         (cs),
        .block        (block),
        .ready        (ready),
        .digest       (core_digest),
        .digest_valid (core_digest_valid)
    );

    // Pass/fail level, held between comparisons
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            digest_valid <= 1'b0;
        end else if (core_digest_valid) begin
            digest_valid <= (core_digest == expected);
        end
    end

endmodule

`default_nettype wire

/* verilog/sha256_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sha256_defs.svh"

module sha256_core (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         init,
    input  wire sha256_pkg::msg_block_t block,
    output logic                        ready,
    output sha256_pkg::digest_t         digest,
    output logic                        digest_valid
);
    import sha256_pkg::*;

    // Initial hash, square roots of the first 8 primes
    localparam digest_t H_INIT = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    core_state_t state;
    round_t      round_ctr;

    // Working variables
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    word_t g;
    word_t h;

    word_t w;
    word_t k;
    word_t t1;
    word_t t2;
    logic  start;
    logic  w_next;

    //==========================================================================
    // Round functions
    //==========================================================================

    function automatic word_t big_sigma0(input word_t x);
        return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
    endfunction

    function automatic word_t big_sigma1(input word_t x);
        return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
    endfunction

    function automatic word_t ch(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (~x & z);
    endfunction

    function automatic word_t maj(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (x & z) ^ (y & z);
    endfunction

    assign start  = init && ready;            // Init is dropped while busy
    assign w_next = (state == CORE_ROUNDS);

    assign t1 = h + big_sigma1(e) + ch(e, f, g) + k + w;
    assign t2 = big_sigma0(a) + maj(a, b, c);

    sha256_w_mem u_w_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .w_init  (start),
        .w_next  (w_next),
        .block   (block),
        .w       (w)
    );

    sha256_k_constants u_k_constants (
        .round (round_ctr),
        .k     (k)
    );

    //==========================================================================
    // Working variables
    //==========================================================================

    always_ff @(posedge clk) begin
        if (start) begin
            {a, b, c, d, e, f, g, h} <= H_INIT;
        end else if (state == CORE_ROUNDS) begin
            h <= g;
            g <= f;
            f <= e;
            e <= d + t1;
            d <= c;
            c <= b;
            b <= a;
            a <= t1 + t2;
        end
    end

    //==========================================================================
    // Control FSM and final hash addition
    //==========================================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= CORE_IDLE;
            round_ctr    <= '0;
            ready        <= 1'b1;
            digest_valid <= 1'b0;
            digest       <= '0;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (start) begin
                        state        <= CORE_ROUNDS;
                        round_ctr    <= '0;
                        ready        <= 1'b0;
                        digest_valid <= 1'b0;
                    end
                end
                CORE_ROUNDS: begin
                    round_ctr <= round_ctr + 1'b1;
                    if (round_ctr == round_t'(`SHA_ROUNDS - 1)) begin
                        state <= CORE_FINAL;   // Last round done
                    end
                end
                CORE_FINAL: begin
                    // Single block, so the chaining value is the initial hash
                    digest <= {
                        H_INIT[255:224] + a, H_INIT[223:192] + b,
                        H_INIT[191:160] + c, H_INIT[159:128] + d,
                        H_INIT[127:96]  + e, H_INIT[95:64]   + f,
                        H_INIT[63:32]   + g, H_INIT[31:0]    + h
                    };
                    ready        <= 1'b1;
                    digest_valid <= 1'b1;
                    state        <= CORE_IDLE;
                end
                default: begin
                    state <= CORE_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/sha256_w_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module sha256_w_mem (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         w_init,
    input  wire                         w_next,
    input  wire sha256_pkg::msg_block_t block,
    output sha256_pkg::word_t           w
);
    import sha256_pkg::*;

    word_t  w_mem [16];    // Sliding window, W[t-16] at index 0
    word_t  w_new;
    round_t w_ctr;         // Round being served

    // Small sigma functions of the message schedule
    function automatic word_t sigma0(input word_t x);
        return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
    endfunction

    function automatic word_t sigma1(input word_t x);
        return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
    endfunction

    //==========================================================================
    // Schedule word
    //==========================================================================

    assign w_new = sigma1(w_mem[14]) + w_mem[9] + sigma0(w_mem[1]) + w_mem[0];

    // First 16 rounds read the block words directly
    assign w = (w_ctr < 16) ? w_mem[w_ctr[3:0]] : w_new;

    //==========================================================================
    // Window and round counter
    //==========================================================================

    always_ff @(posedge clk) begin
        if (w_init) begin
            for (int i = 0; i < 16; i++) begin
                w_mem[i] <= block[511 - 32*i -: 32];   // Big-endian word order
            end
        end else if (w_next && (w_ctr[5:4] != 2'b00)) begin
            for (int i = 0; i < 15; i++) begin
                w_mem[i] <= w_mem[i + 1];
            end
            w_mem[15] <= w_new;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            w_ctr <= '0;
        end else if (w_init) begin
            w_ctr <= '0;
        end else if (w_next) begin
            w_ctr <= w_ctr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/sha256_k_constants.sv */
`timescale 1ns/10ps
`default_nettype none

module sha256_k_constants (
    input  wire sha256_pkg::round_t round,
    output sha256_pkg::word_t       k
);

    // Fractional parts of the cube roots of the first 64 primes
    always_comb begin
        case (round)
            6'd0:  k = 32'h428a2f98;
            6'd1:  k = 32'h71374491;
            6'd2:  k = 32'hb5c0fbcf;
            6'd3:  k = 32'he9b5dba5;
            6'd4:  k = 32'h3956c25b;
            6'd5:  k = 32'h59f111f1;
            6'd6:  k = 32'h923f82a4;
            6'd7:  k = 32'hab1c5ed5;
            6'd8:  k = 32'hd807aa98;
            6'd9:  k = 32'h12835b01;
            6'd10: k = 32'h243185be;
            6'd11: k = 32'h550c7dc3;
            6'd12: k = 32'h72be5d74;
            6'd13: k = 32'h80deb1fe;
            6'd14: k = 32'h9bdc06a7;
            6'd15: k = 32'hc19bf174;
            6'd16: k = 32'he49b69c1;
            6'd17: k = 32'hefbe4786;
            6'd18: k = 32'h0fc19dc6;
            6'd19: k = 32'h240ca1cc;
            6'd20: k = 32'h2de92c6f;
            6'd21: k = 32'h4a7484aa;
            6'd22: k = 32'h5cb0a9dc;
            6'd23: k = 32'h76f988da;
            6'd24: k = 32'h983e5152;
            6'd25: k = 32'ha831c66d;
            6'd26: k = 32'hb00327c8;
            6'd27: k = 32'hbf597fc7;
            6'd28: k = 32'hc6e00bf3;
            6'd29: k = 32'hd5a79147;
            6'd30: k = 32'h06ca6351;
            6'd31: k = 32'h14292967;
            6'd32: k = 32'h27b70a85;
            6'd33: k = 32'h2e1b2138;
            6'd34: k = 32'h4d2c6dfc;
            6'd35: k = 32'h53380d13;
            6'd36: k = 32'h650a7354;
            6'd37: k = 32'h766a0abb;
            6'd38: k = 32'h81c2c92e;
            6'd39: k = 32'h92722c85;
            6'd40: k = 32'ha2bfe8a1;
            6'd41: k = 32'ha81a664b;
            6'd42: k = 32'hc24b8b70;
            6'd43: k = 32'hc76c51a3;
            6'd44: k = 32'hd192e819;
            6'd45: k = 32'hd6990624;
            6'd46: k = 32'hf40e3585;
            6'd47: k = 32'h106aa070;
            6'd48: k = 32'h19a4c116;
            6'd49: k = 32'h1e376c08;
            6'd50: k = 32'h2748774c;
            6'd51: k = 32'h34b0bcb5;
            6'd52: k = 32'h391c0cb3;
            6'd53: k = 32'h4ed8aa4a;
            6'd54: k = 32'h5b9cca4f;
            6'd55: k = 32'h682e6ff3;
            6'd56: k = 32'h748f82ee;
            6'd57: k = 32'h78a5636f;
            6'd58: k = 32'h84c87814;
            6'd59: k = 32'h8cc70208;
            6'd60: k = 32'h90befffa;
            6'd61: k = 32'ha4506ceb;
            6'd62: k = 32'hbef9a3f7;
            6'd63: k = 32'hc67178f2;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sha256_pkg.sv */
`default_nettype none

`include "sha256_defs.svh"

package sha256_pkg;

    // One SHA word, also the host register width
    typedef logic [31:0] word_t;

    typedef logic [`SHA_WORDS*32-1:0] digest_t;   // Hash result or expected digest
    typedef logic [511:0] msg_block_t;             // One padded message block

    typedef logic [$clog2(`SHA_ROUNDS)-1:0] round_t;
    typedef logic [`SHA_ADDR_W-1:0] word_addr_t;

    // Compression engine states
    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_ROUNDS,
        CORE_FINAL
    } core_state_t;

endpackage

`default_nettype wire

/* verilog/sha256_defs.svh */
`ifndef SHA256_DEFS_SVH
`define SHA256_DEFS_SVH

//==========================================================================
// SHA-256 authentication block sizes
//==========================================================================

// Words in a key or digest
`define SHA_WORDS         8

// Register address width
`define SHA_ADDR_W        3

// Compression rounds per block
`define SHA_ROUNDS        64

// Length field of the padded key message, in bits
`define SHA_MSG_LEN_BITS  256

`endif
